/* verification/controlTrace.txt */
# behavior opcodeByte flags length aluOp regWe pcSel lrWe cFlagAfter
# behavior 2 ALU, 3 status, 4 branches, 5 LDW/STW; opcodeByte, flags and aluOp in hex
2 00 1 5 1 1 0 0 1
2 08 0 5 1 1 0 0 0
2 10 1 5 1 1 0 0 1
2 18 0 5 2 1 0 0 0
2 20 1 5 2 1 0 0 1
2 28 0 5 3 1 0 0 0
2 30 1 5 3 1 0 0 1
2 38 0 5 3 1 0 0 0
2 40 1 5 2 1 0 0 1
2 48 0 5 2 1 0 0 0
2 50 1 5 4 1 0 0 1
2 58 0 5 3 0 0 0 0
2 60 1 5 3 0 0 0 1
2 68 0 5 5 1 0 0 0
2 70 1 5 6 1 0 0 1
2 78 0 5 7 1 0 0 0
2 80 1 5 8 1 0 0 1
2 88 0 5 9 1 0 0 0
2 90 1 5 a 1 0 0 1
2 98 0 5 b 1 0 0 0
2 a0 1 5 c 1 0 0 1
2 a8 0 5 d 1 0 0 0
2 b0 f 5 e 1 0 0 0
2 f8 f 5 0 0 0 0 0
3 60 c 5 3 0 0 0 0
3 cc 0 5 1 0 1 0 0
3 cb 0 5 1 0 0 0 0
3 00 1 5 1 1 0 0 1
3 18 0 5 2 1 0 0 0
4 58 0 5 3 0 0 0 0
4 c8 f 5 1 0 1 0 0
4 c9 f 5 1 0 1 0 0
4 ca f 5 1 0 0 0 0
4 cb f 5 1 0 0 0 0
4 cc f 5 1 0 1 0 0
4 cd f 5 1 0 1 1 0
4 ce f 5 1 0 0 0 0
4 cf f 5 1 0 0 0 0
4 58 7 5 3 0 0 0 1
4 c8 0 5 1 0 1 0 1
4 c9 0 5 1 0 0 0 1
4 ca 0 5 1 0 1 0 1
4 cb 0 5 1 0 1 0 1
4 cc 0 5 1 0 0 0 1
4 cd 0 5 1 0 1 1 1
4 ce 0 5 1 0 0 0 1
4 cf 0 5 1 0 0 0 1
5 b8 f 9 1 0 0 0 1
5 c0 f 9 1 0 0 0 1
5 00 0 5 1 1 0 0 0

/* list.f */
+incdir+source
source/controlPkg.sv
source/phaseSequencer.sv
source/conditionUnit.sv
source/datapathDecoder.sv
source/busStrobeGen.sv
source/cpuControl.sv
verification/cpuControlTb.sv

/* Bender.yml */
package:
  name: cpu_control

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/controlPkg.sv
      - source/phaseSequencer.sv
      - source/conditionUnit.sv
      - source/datapathDecoder.sv
      - source/busStrobeGen.sv
      - source/cpuControl.sv
  - target: test
    files:
      - verification/cpuControlTb.sv

/* verification/cpuControlTb.sv */
module cpuControlTb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic [2:0] group;
      logic [7:0] code;
      logic [3:0] flags;
      logic [3:0] length;
      logic [3:0] aluOp;
      logic       regWe;
      logic       pcSel;
      logic       lrWe;
      logic       cFlag;
   } traceLine_t;

   localparam tracePath = "verification/controlTrace.txt";
   localparam logic [4:0] loadOpcode   = 5'd23;
   localparam logic [4:0] storeOpcode  = 5'd24;
   localparam logic [4:0] branchOpcode = 5'd25;

   // strobe words are {ALE, nME, nOE, nWE, ENB, MemEn}
   localparam logic [5:0] strobeAddress  = 6'b111100;
   localparam logic [5:0] strobeRead     = 6'b000101;
   localparam logic [5:0] strobeReadData = 6'b000111;
   localparam logic [5:0] strobeReadEnd  = 6'b010101;
   localparam logic [5:0] strobeWrite    = 6'b001000;
   localparam logic [5:0] strobeIdle     = 6'b010100;

   logic       Clock = 1'b0;
   logic       nReset;
   logic [7:0] OpcodeCondIn;
   logic [3:0] Flags;
   logic [3:0] AluOp;
   logic       Op1Sel, Op2Sel, ImmSel, Rs1Sel, WdSel, PcSel;
   logic       AluEn, AluWe, LrWe, PcWe, PcEn, IrWe, RegWe;
   logic       MemEn, nWE, nOE, nME, ENB, ALE;
   logic       CFlag;

   traceLine_t trace[$];
   int         checkCount [1:5] = '{default: 0};
   int         errorCount [1:5] = '{default: 0};
   int         setupErrors = 0;
   int         currentLine = 0;
   int         cycleCount = 0;
   int         cycleLimit = 20;

   cpuControl UUT (.*);

   always #10 Clock = ~Clock;

   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("Timeout: the run went past %0d clock cycles", cycleLimit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic compareValue(input string what, input logic [15:0] got,
                               input logic [15:0] expected, input int group);
      checkCount[group]++;
      assert (got === expected) else begin
         errorCount[group]++;
         $display("Mismatch at %0d ns: line %0d %s is %0h, expected %0h",
                  $time, currentLine, what, got, expected);
      end
   endtask

   function automatic logic [5:0] readStrobes(input int phase);
      case (phase)
         0: return strobeAddress;
         1: return strobeRead;
         2: return strobeReadData;
         default: return strobeReadEnd;
      endcase
   endfunction

   // LDW replays the fetch read from Exec2, STW writes in Exec3 and Exec4
   function automatic logic [5:0] execStrobes(input logic isLoad, input logic isStore,
                                              input int execStep);
      if (isLoad && execStep >= 2) return readStrobes(execStep - 2);
      if (isStore && execStep == 2) return strobeAddress;
      if (isStore && (execStep == 3 || execStep == 4)) return strobeWrite;
      return strobeIdle;
   endfunction

   task automatic loadTrace();
      int    fd;
      int    fields;
      int    f [9];
      string text;
      traceLine_t entry;
      fd = $fopen(tracePath, "r");
      if (fd == 0) begin
         $display("Could not open the trace file %s", tracePath);
         setupErrors++;
      end else begin
         while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 0 && text[0] != "#") begin
               fields = $sscanf(text, "%d %h %h %d %h %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
               if (fields == 9) begin
                  entry.group  = 3'(f[0]);
                  entry.code   = 8'(f[1]);
                  entry.flags  = 4'(f[2]);
                  entry.length = 4'(f[3]);
                  entry.aluOp  = 4'(f[4]);
                  entry.regWe  = f[5][0];
                  entry.pcSel  = f[6][0];
                  entry.lrWe   = f[7][0];
                  entry.cFlag  = f[8][0];
                  trace.push_back(entry);
               end
            end
         end
         $fclose(fd);
      end
      if (trace.size() == 0) begin
         $display("The trace holds no instructions to run");
         setupErrors++;
      end
   endtask

   // entered on the falling edge of the first fetch cycle, leaves on the next one
   task automatic runInstruction(input int index);
      traceLine_t t;
      int         fetchStep;
      int         execStep;
      logic       isLoad;
      logic       isStore;
      logic       isBranch;
      t = trace[index];
      isLoad = (t.code[7:3] == loadOpcode);
      isStore = (t.code[7:3] == storeOpcode);
      isBranch = (t.code[7:3] == branchOpcode);
      fetchStep = 0;
      do begin
         if (fetchStep > 0) @(negedge Clock);
         compareValue("fetch strobes", {ALE, nME, nOE, nWE, ENB, MemEn},
                      readStrobes(fetchStep), 1);
         compareValue("fetch controls", {PcEn, IrWe, PcWe, RegWe, AluEn, AluWe, LrWe},
                      {fetchStep == 0, fetchStep == 3, 5'b00000}, 1);
         fetchStep++;
      end while (!IrWe && fetchStep < 4);
      checkCount[1]++;
      assert (IrWe) else begin
         errorCount[1]++;
         $display("IrWe never rose during the fetch of line %0d", currentLine);
      end
      OpcodeCondIn = t.code;   // IR contents from here to the next Fetch4
      Flags = t.flags;
      execStep = 0;
      do begin
         @(negedge Clock);
         execStep++;
         if (execStep == 1) begin
            compareValue("AluOp", AluOp, t.aluOp, t.group);
            compareValue("RegWe", RegWe, t.regWe, t.group);
            compareValue("PcSel", PcSel, t.pcSel, t.group);
            compareValue("LrWe", LrWe, t.lrWe, t.group);
            compareValue("Op1Sel", Op1Sel, isBranch, t.group);   // PC-relative target
         end else begin
            compareValue("RegWe", RegWe, isLoad && execStep == 5, t.group);
         end
         compareValue("WdSel", WdSel, isLoad && execStep == 5, t.group);
         compareValue("IrWe", IrWe, 1'b0, t.group);
         if (isStore && execStep == 4) compareValue("AluEn", AluEn, 1'b1, t.group);
         compareValue("execute strobes", {ALE, nME, nOE, nWE, ENB, MemEn},
                      execStrobes(isLoad, isStore, execStep), t.group);
      end while (!PcWe && execStep < 5);
      compareValue("instruction length", 4 + execStep, t.length, t.group);
      @(negedge Clock);
      compareValue("CFlag", CFlag, t.cFlag, t.group);
   endtask

   task automatic reportBehavior(input int group);
      string name;
      case (group)
         1: name = "reset and fetch strobes";
         2: name = "ALU opcodes";
         3: name = "status capture";
         4: name = "branch conditions";
         default: name = "LDW and STW";
      endcase
      $display("behavior %0d (%s): %0d checks, %0d errors",
               group, name, checkCount[group], errorCount[group]);
   endtask

   initial begin
      int lastGroup;
      int totalChecks;
      int totalErrors;
      nReset = 1'b0;
      OpcodeCondIn = 8'hf8;   // unused opcode, no-op
      Flags = 4'h0;
      loadTrace();
      cycleLimit = trace.size() * 9 + 20;
      repeat (2) begin
         @(negedge Clock);
         compareValue("reset outputs",
                      {RegWe, PcWe, IrWe, AluWe, AluEn, LrWe, MemEn, ENB, nME}, 9'b1, 1);
      end
      nReset = 1'b1;
      lastGroup = 0;
      for (int i = 0; i < trace.size(); i++) begin
         currentLine = i + 1;
         if (lastGroup != 0 && trace[i].group != lastGroup) reportBehavior(lastGroup);
         lastGroup = trace[i].group;
         runInstruction(i);
      end
      if (lastGroup != 0) reportBehavior(lastGroup);
      reportBehavior(1);
      totalChecks = 0;
      totalErrors = setupErrors;
      for (int g = 1; g <= 5; g++) begin
         totalChecks += checkCount[g];
         totalErrors += errorCount[g];
      end
      $display("%0d instructions, %0d checks, %0d errors",
               trace.size(), totalChecks, totalErrors);
      if (totalErrors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* source/cpuControl.sv */
`include "control_cfg.svh"

module cpuControl import controlPkg::*; (
   input  logic                                  Clock,
   input  logic                                  nReset,
   input  logic [`OPCODE_WIDTH+`BRANCH_WIDTH-1:0] OpcodeCondIn,
   input  logic [`FLAGS_WIDTH-1:0]               Flags,
   output aluFunction_t                          AluOp,
   output op1Select_t                            Op1Sel,
   output op2Select_t                            Op2Sel,
   output immSelect_t                            ImmSel,
   output rs1Select_t                            Rs1Sel,
   output wdSelect_t                             WdSel,
   output pcSelect_t                             PcSel,
   output logic                                  AluEn,
   output logic                                  AluWe,
   output logic                                  LrWe,
   output logic                                  PcWe,
   output logic                                  PcEn,
   output logic                                  IrWe,
   output logic                                  RegWe,
   output logic                                  MemEn,   // pad direction
   output logic                                  nWE,
   output logic                                  nOE,
   output logic                                  nME,
   output logic                                  ENB,
   output logic                                  ALE,
   output logic                                  CFlag
);

   opcode_t      opcode;
   branchCode_t  branchCode;
   controlStep_t step;
   logic         branchTaken;
   logic         statusWe;

   // upper bits name the operation, lower bits the branch condition
   assign opcode     = opcode_t'(OpcodeCondIn[`BRANCH_WIDTH +: `OPCODE_WIDTH]);
   assign branchCode = branchCode_t'(OpcodeCondIn[`BRANCH_WIDTH-1:0]);

   phaseSequencer sequencer (
      .Clock  (Clock),
      .nReset (nReset),
      .opcode (opcode),
      .step   (step)
   );

   conditionUnit condition (
      .Clock       (Clock),
      .nReset      (nReset),
      .Flags       (Flags),
      .statusWe    (statusWe),
      .branchCode  (branchCode),
      .branchTaken (branchTaken),
      .CFlag       (CFlag)
   );

   datapathDecoder decoder (
      .step        (step),
      .opcode      (opcode),
      .branchCode  (branchCode),
      .branchTaken (branchTaken),
      .AluOp       (AluOp),
      .Op1Sel      (Op1Sel),
      .Op2Sel      (Op2Sel),
      .ImmSel      (ImmSel),
      .Rs1Sel      (Rs1Sel),
      .WdSel       (WdSel),
      .PcSel       (PcSel),
      .AluEn       (AluEn),
      .AluWe       (AluWe),
      .LrWe        (LrWe),
      .PcWe        (PcWe),
      .PcEn        (PcEn),
      .IrWe        (IrWe),
      .RegWe       (RegWe),
      .statusWe    (statusWe)
   );

   busStrobeGen strobes (
      .step   (step),
      .opcode (opcode),
      .MemEn  (MemEn),
      .nWE    (nWE),
      .nOE    (nOE),
      .nME    (nME),
      .ENB    (ENB),
      .ALE    (ALE)
   );

endmodule

/* source/busStrobeGen.sv */
module busStrobeGen import controlPkg::*; (
   input  controlStep_t step,
   input  opcode_t      opcode,
   output logic         MemEn,
   output logic         nWE,
   output logic         nOE,
   output logic         nME,
   output logic         ENB,
   output logic         ALE
);

   logic         readCycle;
   controlStep_t readPhase;
   logic         storeExec;

   // LDW reuses the fetch read pattern, shifted into Exec2..Exec5
   always_comb begin
      readCycle = 1'b1;
      readPhase = step;
      case (step)
         Fetch1, Fetch2, Fetch3, Fetch4: ;
         Exec2: readPhase = Fetch1;
         Exec3: readPhase = Fetch2;
         Exec4: readPhase = Fetch3;
         Exec5: readPhase = Fetch4;
         default: readCycle = 1'b0;
      endcase
      if (step >= Exec1 && opcode != LDW) begin
         readCycle = 1'b0;
      end
   end

   assign storeExec = (opcode == STW) && (step inside {[Exec1:Exec5]});

   always_comb begin
      MemEn = 1'b0;
      nWE   = 1'b1;
      nOE   = 1'b0;
      nME   = 1'b1;
      ENB   = 1'b0;
      ALE   = 1'b0;
      if (readCycle) begin
         case (readPhase)
            Fetch1: begin
               ALE = 1'b1;   // address phase
               nOE = 1'b1;
            end
            Fetch2: begin
               nME   = 1'b0;
               MemEn = 1'b1;
            end
            Fetch3: begin
               nME   = 1'b0;
               MemEn = 1'b1;
               ENB   = 1'b1;   // read data onto the system bus
            end
            Fetch4: MemEn = 1'b1;
            default: ;
         endcase
      end else if (storeExec) begin
         case (step)
            Exec2: begin
               ALE = 1'b1;
               nOE = 1'b1;
            end
            Exec3, Exec4: begin
               nME = 1'b0;
               nOE = 1'b1;
               nWE = 1'b0;   // write strobe over two steps
            end
            default: ;
         endcase
      end
   end

   // a store drives the bus itself, so the pad buffer must stay off
   storeKeepsPadOff: assert final (!(storeExec && ENB && nOE))
      else $error("ENB high with nOE high during a store in step %s", step.name());

endmodule

/* source/datapathDecoder.sv */
module datapathDecoder import controlPkg::*; (
   input  controlStep_t step,
   input  opcode_t      opcode,
   input  branchCode_t  branchCode,
   input  logic         branchTaken,
   output aluFunction_t AluOp,
   output op1Select_t   Op1Sel,
   output op2Select_t   Op2Sel,
   output immSelect_t   ImmSel,
   output rs1Select_t   Rs1Sel,
   output wdSelect_t    WdSel,
   output pcSelect_t    PcSel,
   output logic         AluEn,
   output logic         AluWe,
   output logic         LrWe,
   output logic         PcWe,
   output logic         PcEn,
   output logic         IrWe,
   output logic         RegWe,
   output logic         statusWe
);

   logic aluInstr;
   logic memOp;

   function automatic aluFunction_t aluFunctionOf(opcode_t op);
      case (op)
         ADD, ADDI, ADDIB:            return FnADD;
         ADC, ADCI, SUC, SUCI:        return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:                         return FnNEG;
         AND:                         return FnAND;
         OR:                          return FnOR;
         XOR:                         return FnXOR;
         NOT:                         return FnNOT;
         NAND:                        return FnNAND;
         NOR:                         return FnNOR;
         LSL:                         return FnLSL;
         LSR:                         return FnLSR;
         ASR:                         return FnASR;
         LUI:                         return FnLUI;
         default:                     return FnNOP;
      endcase
   endfunction

   assign aluInstr = opcode inside {[ADD:LUI]};
   assign memOp    = opcode inside {LDW, STW};

   always_comb begin
      AluOp    = FnNOP;
      Op1Sel   = Op1Rd1;
      Op2Sel   = Op2Imm;
      ImmSel   = ImmLong;
      Rs1Sel   = Rs1Ra;
      WdSel    = WdAlu;
      PcSel    = Pc1;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      LrWe     = 1'b0;
      PcWe     = 1'b0;
      PcEn     = 1'b0;
      IrWe     = 1'b0;
      RegWe    = 1'b0;
      statusWe = 1'b0;
      case (step)
         Fetch1: PcEn = 1'b1;   // PC out to the address latch
         Fetch4: IrWe = 1'b1;
         Exec1: begin
            if (aluInstr) begin
               AluOp    = aluFunctionOf(opcode);
               PcWe     = 1'b1;
               PcEn     = (opcode != LUI);
               RegWe    = !(opcode inside {CMP, CMPI});   // compares only set flags
               statusWe = (opcode != LUI);
               if (opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR}) begin
                  Op2Sel = Op2Rd2;
               end
               if (opcode inside {ADDI, SUBI, CMPI, LSL, LSR, ASR}) begin
                  ImmSel = ImmShort;
               end
               if (opcode inside {ADDIB, SUBIB}) begin
                  Rs1Sel = Rs1Rd;   // byte immediate forms add into Rd
               end
            end else begin
               case (opcode)
                  LDW, STW: begin
                     AluOp  = FnADD;   // effective address
                     ImmSel = ImmShort;
                     AluWe  = 1'b1;
                  end
                  BRANCH: begin
                     AluOp  = FnADD;   // PC plus long offset
                     Op1Sel = Op1Pc;
                     PcWe   = 1'b1;
                     if (branchTaken) begin
                        PcSel = PcAluOut;
                        LrWe  = (branchCode == BWL);
                     end
                  end
                  default: PcWe = 1'b1;
               endcase
            end
         end
         Exec2: begin
            if (memOp) begin
               AluOp  = FnADD;
               ImmSel = ImmShort;
               AluEn  = 1'b1;   // address onto the bus
            end
         end
         Exec3: begin
            if (memOp) begin
               AluOp  = FnA;   // pass Rd through for store data
               Rs1Sel = Rs1Rd;
               AluWe  = 1'b1;
               AluEn  = 1'b1;
            end
         end
         Exec4: AluEn = (opcode == STW);   // hold store data
         Exec5: begin
            if (memOp) begin
               PcWe = 1'b1;
               if (opcode == LDW) begin
                  WdSel = WdSys;
                  RegWe = 1'b1;
               end
            end
         end
         default: ;
      endcase
   end

   // a register write in Fetch4 would land on a half-loaded IR
   regWriteNotOnIrLoad: assert final (!(RegWe && IrWe))
      else $error("RegWe and IrWe high together in step %s", step.name());

endmodule

/* source/conditionUnit.sv */
`include "control_cfg.svh"

module conditionUnit import controlPkg::*; (
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic [`FLAGS_WIDTH-1:0] Flags,
   input  logic                    statusWe,
   input  branchCode_t             branchCode,
   output logic                    branchTaken,
   output logic                    CFlag
);

   logic [`FLAGS_WIDTH-1:0] statusReg;
   logic                    zero;
   logic                    lessThan;

   // ALU flags captured at the end of a flag-setting execute step
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;
      end
   end

   assign zero     = statusReg[`FLAGS_Z];
   assign lessThan = statusReg[`FLAGS_N] ^ statusReg[`FLAGS_V];   // signed compare result

   always_comb begin
      case (branchCode)
         BR, BWL: branchTaken = 1'b1;
         BNE:     branchTaken = !zero;
         BE:      branchTaken = zero;
         BLT:     branchTaken = lessThan;
         BGE:     branchTaken = !lessThan;
         default: branchTaken = 1'b0;
      endcase
   end

   assign CFlag = statusReg[`FLAGS_C];   // carry in for ADC and SUC

endmodule

/* source/phaseSequencer.sv */
`include "control_cfg.svh"

module phaseSequencer import controlPkg::*; (
   input  logic         Clock,
   input  logic         nReset,
   input  opcode_t      opcode,
   output controlStep_t step
);

   logic         memOp;
   logic [2:0]   execLength;
   controlStep_t lastStep;
   controlStep_t nextStep;

   assign memOp = opcode inside {LDW, STW};

   // number of execute steps for the instruction in the IR
   assign execLength = memOp ? 3'(`MEM_EXEC_STEPS) : 3'd1;

   always_comb begin
      lastStep = controlStep_t'(4'(Exec1) + 4'(execLength) - 4'd1);
   end

   always_comb begin
      if (step > Exec5) begin
         nextStep = Fetch1;   // unused encodings recover to fetch
      end else if (step == lastStep) begin
         nextStep = Fetch1;
      end else begin
         nextStep = controlStep_t'(step + 4'd1);   // fetch steps fall through to Exec1
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         step <= Fetch1;
      end else begin
         step <= nextStep;
      end
   end

   // only the memory instructions get past the first execute step
   execTwoOnlyForMemory: assert property (
      @(posedge Clock) disable iff (!nReset)
      (step == Exec1 && !(opcode inside {LDW, STW})) |=> step != Exec2
   ) else $error("Exec2 entered for a single-step opcode");

endmodule

/* source/controlPkg.sv */
package controlPkg;

   typedef enum logic [4:0] {
      ADD,
      ADDI,
      ADDIB,
      ADC,
      ADCI,
      SUB,
      SUBI,
      SUBIB,
      SUC,
      SUCI,
      NEG,
      CMP,
      CMPI,
      AND,
      OR,
      XOR,
      NOT,
      NAND,
      NOR,
      LSL,
      LSR,
      ASR,
      LUI,
      LDW,
      STW,
      BRANCH
   } opcode_t;   // codes 26 to 31 run as a no-op

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5
   } branchCode_t;   // 6 and 7 never taken

   typedef enum logic [3:0] {
      FnNOP, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnA
   } aluFunction_t;

   typedef enum logic {Op1Rd1, Op1Pc} op1Select_t;
   typedef enum logic {Op2Imm, Op2Rd2} op2Select_t;
   typedef enum logic {WdAlu, WdSys} wdSelect_t;
   typedef enum logic {ImmLong, ImmShort} immSelect_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Select_t;
   typedef enum logic {Pc1, PcAluOut} pcSelect_t;

   typedef enum logic [3:0] {
      Fetch1,
      Fetch2,
      Fetch3,
      Fetch4,
      Exec1,
      Exec2,
      Exec3,
      Exec4,
      Exec5
   } controlStep_t;

endpackage

/* source/control_cfg.svh */
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// instruction byte split, opcode in the upper bits
`define OPCODE_WIDTH 5
`define BRANCH_WIDTH 3

// status word from the ALU
`define FLAGS_WIDTH 4

`define FLAGS_C 0   // carry
`define FLAGS_Z 1   // zero
`define FLAGS_N 2   // negative
`define FLAGS_V 3   // overflow

// LDW and STW run their own bus cycle after the address add
`define MEM_EXEC_STEPS 5

`endif
